/* tb.f */
common/i2c_pkg.sv
i2c_ctrl/i2c_ctrl_fsm.sv
i2c_ctrl/i2c_bit_engine.sv
design/i2c_rx_capture.sv
design/i2c_dri.sv
bench/tb_clk_gen.sv
bench/eeprom_model.sv
bench/tb_checker.sv
bench/tb_top.sv

/* Makefile */
# Verilator build for the I2C controller testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_top.sv */
`default_nettype none

module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [6:0] SLAVE_ADDR = 7'h1a;
    localparam int TIMEOUT_CYC = 2000; // longest transfer is near 200 cycles

    logic        dri_clk;
    logic        rst_n;
    logic        i2c_exec;
    logic        bit_ctrl;
    logic        i2c_rh_wl;
    logic [15:0] i2c_addr;
    logic [7:0]  i2c_data_w;
    logic [7:0]  i2c_data_r;
    logic        i2c_done;
    logic        i2c_ack;
    logic        scl;
    logic        slave_present;
    wire         sda;

    int          err_cnt;
    int          check_cnt;
    int          frame_cnt;
    int          tb_errs = 0;
    int          n_req = 0;
    int          test_base = 0;
    int          seed;
    logic [7:0]  used_addr [$];
    event        abort_ev;

    pullup (sda);

    tb_clk_gen clk_gen_i (
        .dri_clk (dri_clk),
        .rst_n   (rst_n)
    );

    i2c_dri #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) dut_i (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .i2c_ack    (i2c_ack),
        .scl        (scl),
        .sda        (sda)
    );

    eeprom_model #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) slave_i (
        .scl     (scl),
        .sda     (sda),
        .present (slave_present)
    );

    tb_checker #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) chk_i (
        .dri_clk       (dri_clk),
        .rst_n         (rst_n),
        .i2c_exec      (i2c_exec),
        .bit_ctrl      (bit_ctrl),
        .i2c_rh_wl     (i2c_rh_wl),
        .i2c_addr      (i2c_addr),
        .i2c_data_w    (i2c_data_w),
        .i2c_data_r    (i2c_data_r),
        .i2c_done      (i2c_done),
        .i2c_ack       (i2c_ack),
        .scl           (scl),
        .sda           (sda),
        .slave_present (slave_present),
        .err_cnt       (err_cnt),
        .check_cnt     (check_cnt),
        .frame_cnt     (frame_cnt)
    );

    initial begin
        @(abort_ev);
        $display("Verification failed");
        $finish;
    end

    task automatic abort_run(input string what);
        $display("Error at %0t ns: %s", $time, what);
        -> abort_ev;
        forever @(posedge dri_clk); // parked until the run ends
    endtask

    task automatic start_req(input logic rd, input logic wide, input logic [15:0] addr,
                             input logic [7:0] data);
        @(posedge dri_clk);
        i2c_exec   <= 1'b1;
        bit_ctrl   <= wide;
        i2c_rh_wl  <= rd;
        i2c_addr   <= addr;
        i2c_data_w <= data;
        @(posedge dri_clk);
        i2c_exec <= 1'b0;
    endtask

    task automatic wait_done();
        int cnt;
        cnt = 0;
        do begin
            @(posedge dri_clk);
            cnt++;
        end while (!i2c_done && cnt < TIMEOUT_CYC);
        if (!i2c_done) begin
            abort_run("timeout waiting for i2c_done");
        end
    endtask

    task automatic transfer(input logic rd, input logic wide, input logic [15:0] addr,
                            input logic [7:0] data);
        start_req(rd, wide, addr, data);
        n_req++;
        wait_done();
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, err_cnt + tb_errs - test_base);
        test_base = err_cnt + tb_errs;
    endtask

    initial begin
        logic [31:0] r;
        logic [7:0]  lo;
        int          cnt;
        int          dones;

        seed          = 32'h8c00;
        i2c_exec      = 1'b0;
        bit_ctrl      = 1'b0;
        i2c_rh_wl     = 1'b0;
        i2c_addr      = '0;
        i2c_data_w    = '0;
        slave_present = 1'b1;

        cnt = 0;
        do begin
            @(posedge dri_clk);
            cnt++;
        end while (rst_n !== 1'b1 && cnt < 20);
        if (rst_n !== 1'b1) begin
            abort_run("reset was never released");
        end
        repeat (6) @(posedge dri_clk);
        end_test("1 idle after reset");

        for (int i = 0; i < 12; i++) begin
            r  = $random(seed);
            lo = (i >= 4 && r[24]) ? used_addr[i - 4] : r[7:0]; // some rewrites
            transfer(1'b0, r[25], {r[15:8], lo}, r[23:16]);
            used_addr.push_back(lo);
            r = $random(seed);
            transfer(1'b1, r[25], {r[15:8], lo}, r[23:16]); // random width and high byte
        end
        end_test("2 write and read back");

        @(posedge dri_clk);
        slave_present <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            transfer(i[0], r[25], {r[15:8], used_addr[i]}, r[23:16]); // write on even i
        end
        @(posedge dri_clk);
        slave_present <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            transfer(1'b1, r[25], {r[15:8], used_addr[i]}, 8'h00);
        end
        end_test("3 absent slave");

        r = $random(seed);
        start_req(1'b0, r[25], r[15:0], r[23:16]);
        n_req++;
        repeat (30) @(posedge dri_clk);
        r = $random(seed);
        start_req(1'b1, r[25], r[15:0], r[23:16]); // ignored while busy
        wait_done();
        dones = 0;
        repeat (400) begin
            @(posedge dri_clk);
            if (i2c_done) begin
                dones++;
            end
        end
        if (dones != 0) begin
            tb_errs++;
            $display("Fail at %0t ns: i2c_done pulses = %0d, expected 0", $time, dones);
        end
        end_test("4 done pulse");

        $display("test 5 bus framing: %0d frames checked", frame_cnt);
        $display("transfers %0d, checks %0d, errors %0d", n_req, check_cnt,
                 err_cnt + tb_errs);
        if (err_cnt + tb_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_checker.sv */
`default_nettype none

module tb_checker #(
    parameter logic [6:0] SLAVE_ADDR = 7'h1a
) (
    input  wire        dri_clk,
    input  wire        rst_n,
    input  wire        i2c_exec,
    input  wire        bit_ctrl,
    input  wire        i2c_rh_wl,
    input  wire [15:0] i2c_addr,
    input  wire [7:0]  i2c_data_w,
    input  wire [7:0]  i2c_data_r,
    input  wire        i2c_done,
    input  wire        i2c_ack,
    input  wire        scl,
    input  wire        sda,
    input  wire        slave_present,
    output int         err_cnt,
    output int         check_cnt,
    output int         frame_cnt
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  ref_mem [0:255];
    bit          ref_valid [0:255];
    logic        busy = 1'b0;
    logic        done_q = 1'b0;
    logic        req_rd = 1'b0;
    logic        req_wide = 1'b0;
    logic        req_present = 1'b0;
    logic [15:0] req_addr = '0;
    logic [7:0]  req_data = '0;
    int          idle_cyc = 0;
    int          last_stop_cnt = 0;

    // bus monitor state
    logic        prev_scl = 1'b1;
    logic        prev_sda = 1'b1;
    logic        in_frame = 1'b0;
    logic        pend_ok = 1'b0;
    logic [7:0]  first_byte = '0;
    int          fr_bits = 0;
    int          stop_bits = 0;
    int          restarts = 0;
    int          restart_bits = 0;
    int          stop_cnt = 0;

    initial begin
        err_cnt   = 0;
        check_cnt = 0;
        frame_cnt = 0;
    end

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        err_cnt++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic check_frame();
        int exp_bytes;
        exp_bytes = (req_rd ? 4 : 3) + (req_wide ? 1 : 0);
        frame_cnt++;
        if (stop_cnt == last_stop_cnt) begin
            report_error("transfer ended without a stop condition on the bus");
        end else begin
            check_val("bus bit count", 16'(stop_bits), 16'(9 * exp_bytes));
            check_val("first bus byte", 16'(first_byte), 16'({SLAVE_ADDR, 1'b0}));
            check_val("restart count", 16'(restarts), 16'(req_rd));
            if (req_rd) begin
                check_val("bits before restart", 16'(restart_bits),
                          16'(9 * (req_wide ? 3 : 2)));
            end
        end
        last_stop_cnt = stop_cnt;
    endtask

    task automatic finish_transfer();
        check_val("i2c_ack", 16'(i2c_ack), req_present ? 16'd0 : 16'd1);
        if (req_present && !req_rd) begin
            ref_mem[req_addr[7:0]]   = req_data; // slave keys on the low byte
            ref_valid[req_addr[7:0]] = 1'b1;
        end
        if (req_present && req_rd && ref_valid[req_addr[7:0]]) begin
            check_val("i2c_data_r", 16'(i2c_data_r), 16'(ref_mem[req_addr[7:0]]));
        end
        check_frame();
    endtask

    always @(posedge dri_clk) begin
        if (!rst_n) begin
            busy     = 1'b0;
            done_q   = 1'b0;
            idle_cyc = 0;
        end else begin
            if (idle_cyc < 3) begin
                idle_cyc++;
                if (idle_cyc == 3 && !busy) begin
                    check_val("scl", 16'(scl), 16'd1);
                    check_val("sda", 16'(sda), 16'd1);
                    check_val("i2c_done", 16'(i2c_done), 16'd0);
                    check_val("i2c_ack", 16'(i2c_ack), 16'd0);
                end
            end
            if (i2c_done && done_q) begin
                report_error("i2c_done stayed high for more than one cycle");
            end else if (i2c_done) begin
                if (!busy) begin
                    report_error("i2c_done without an accepted request");
                end else begin
                    finish_transfer();
                end
                busy = 1'b0;
            end
            done_q = i2c_done;
            if (i2c_exec && !busy) begin
                busy        = 1'b1;
                req_rd      = i2c_rh_wl;
                req_wide    = bit_ctrl;
                req_addr    = i2c_addr;
                req_data    = i2c_data_w;
                req_present = slave_present;
            end
        end
    end

    // a bit counts once scl falls without a start or stop in its high time
    always @(scl or sda) begin
        if (rst_n === 1'b1) begin
            if (prev_scl === 1'b0 && scl === 1'b1) begin
                pend_ok = 1'b1;
                if (in_frame && fr_bits < 8) begin
                    first_byte = {first_byte[6:0], sda};
                end
            end else if (prev_scl === 1'b1 && scl === 1'b0) begin
                if (in_frame && pend_ok) begin
                    fr_bits++;
                end
                pend_ok = 1'b0;
            end else if (prev_scl === 1'b1 && scl === 1'b1) begin
                if (prev_sda === 1'b1 && sda === 1'b0) begin
                    if (in_frame) begin
                        restarts++;
                        restart_bits = fr_bits;
                    end else begin
                        in_frame   = 1'b1;
                        fr_bits    = 0;
                        restarts   = 0;
                        first_byte = '0;
                    end
                    pend_ok = 1'b0;
                end else if (prev_sda === 1'b0 && sda === 1'b1 && in_frame) begin
                    in_frame  = 1'b0;
                    stop_bits = fr_bits;
                    stop_cnt++;
                    pend_ok = 1'b0;
                end
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

`default_nettype wire

/* bench/eeprom_model.sv */
`default_nettype none

module eeprom_model #(
    parameter logic [6:0] SLAVE_ADDR = 7'h1a
) (
    input  wire scl,
    inout  wire sda,
    input  wire present
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] mem [0:255];
    logic [7:0] wbuf [0:3];        // bytes after the slave address
    logic [7:0] sr = 8'h00;
    logic [7:0] tx_sr = 8'h00;
    logic [7:0] ptr = 8'h00;
    logic       prev_scl = 1'b1;
    logic       prev_sda = 1'b1;
    logic       active = 1'b0;
    logic       addressed = 1'b0;
    logic       start_tx = 1'b0;
    logic       tx_mode = 1'b0;
    logic       ack_now = 1'b0;
    logic       drive_low = 1'b0;
    int         bit_cnt = 0;
    int         byte_idx = 0;
    int         nb = 0;

    assign sda = drive_low ? 1'b0 : 1'bz; // open drain

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'h5a;
        end
    end

    task automatic take_byte();
        if (byte_idx == 0) begin
            addressed = present && (sr[7:1] == SLAVE_ADDR);
            start_tx  = addressed && sr[0];
            ack_now   = addressed;
            nb        = 0;
        end else begin
            ack_now = addressed;
            if (addressed && nb < 4) begin
                wbuf[2'(nb)] = sr;
                nb++;
            end
        end
        byte_idx++;
    endtask

    task automatic clock_rise();
        if (bit_cnt < 8) begin
            if (!tx_mode) begin
                sr = {sr[6:0], sda};
            end
            bit_cnt++;
            if (bit_cnt == 8 && !tx_mode) begin
                take_byte();
            end
        end else begin
            bit_cnt = 0; // ack clock
            if (tx_mode) begin
                if (sda === 1'b1) begin
                    tx_mode = 1'b0; // master nack ends the read
                end else begin
                    ptr   = ptr + 8'd1;
                    tx_sr = mem[ptr];
                end
            end else if (start_tx) begin
                start_tx = 1'b0;
                tx_mode  = 1'b1;
                tx_sr    = mem[ptr];
            end
        end
    endtask

    task automatic clock_fall();
        if (bit_cnt == 8) begin
            drive_low = tx_mode ? 1'b0 : ack_now;
        end else if (tx_mode) begin
            drive_low = !tx_sr[3'(7 - bit_cnt)];
        end else begin
            drive_low = 1'b0;
        end
    endtask

    task automatic frame_start();
        if (active && addressed && nb > 0) begin
            ptr = wbuf[2'(nb - 1)]; // restart keeps the word pointer
        end
        active    = 1'b1;
        addressed = 1'b0;
        start_tx  = 1'b0;
        tx_mode   = 1'b0;
        drive_low = 1'b0;
        bit_cnt   = 0;
        byte_idx  = 0;
        nb        = 0;
    endtask

    task automatic frame_stop();
        if (addressed && nb >= 2) begin
            mem[wbuf[2'(nb - 2)]] = wbuf[2'(nb - 1)];
        end
        active    = 1'b0;
        tx_mode   = 1'b0;
        drive_low = 1'b0;
    endtask

    always @(scl or sda) begin
        if (prev_scl === 1'b0 && scl === 1'b1) begin
            if (active) begin
                clock_rise();
            end
        end else if (prev_scl === 1'b1 && scl === 1'b0) begin
            if (active) begin
                clock_fall();
            end
        end else if (prev_scl === 1'b1 && scl === 1'b1) begin
            if (prev_sda === 1'b1 && sda === 1'b0) begin
                frame_start();
            end else if (prev_sda === 1'b0 && sda === 1'b1 && active) begin
                frame_stop();
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

`default_nettype wire

/* bench/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen (
    output logic dri_clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        dri_clk = 1'b0;
        forever #20 dri_clk = ~dri_clk; // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge dri_clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* design/i2c_dri.sv */
`default_nettype none

module i2c_dri #(
    parameter logic [i2c_pkg::SLV_ADDR_W-1:0] SLAVE_ADDR = 7'h1a
) (
    input  logic                        dri_clk,
    input  logic                        rst_n,
    input  logic                        i2c_exec,
    input  logic                        bit_ctrl,   // 1: 16-bit word address
    input  logic                        i2c_rh_wl,  // 1: read
    input  logic [i2c_pkg::ADDR_W-1:0]  i2c_addr,
    input  logic [i2c_pkg::DATA_W-1:0]  i2c_data_w,
    output logic [i2c_pkg::DATA_W-1:0]  i2c_data_r,
    output logic                        i2c_done,
    output logic                        i2c_ack,    // 1: slave did not ack
    output logic                        scl,
    inout  wire                         sda
);

    import i2c_pkg::*;

    i2c_state_e         phase;
    logic [DATA_W-1:0]  tx_byte;
    logic               phase_done;
    logic               xfer_start;
    logic               sda_out;
    logic               sda_dir;
    logic               sda_in;
    logic               bit_sample;
    logic               ack_sample;
    logic               byte_end;

    assign sda    = sda_dir ? sda_out : 1'bz; // pull-up is off chip
    assign sda_in = sda;

    i2c_ctrl_fsm #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) u_ctrl_fsm (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .phase_done (phase_done),
        .phase      (phase),
        .tx_byte    (tx_byte),
        .xfer_start (xfer_start),
        .i2c_done   (i2c_done)
    );

    i2c_bit_engine u_bit_engine (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .tx_byte    (tx_byte),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_dir    (sda_dir),
        .phase_done (phase_done),
        .bit_sample (bit_sample),
        .ack_sample (ack_sample),
        .byte_end   (byte_end)
    );

    i2c_rx_capture u_rx_capture (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .sda_in     (sda_in),
        .bit_sample (bit_sample),
        .ack_sample (ack_sample),
        .byte_end   (byte_end),
        .xfer_start (xfer_start),
        .i2c_data_r (i2c_data_r),
        .i2c_ack    (i2c_ack)
    );

endmodule

`default_nettype wire

/* design/i2c_rx_capture.sv */
`default_nettype none

module i2c_rx_capture (
    input  logic                        dri_clk,
    input  logic                        rst_n,
    input  logic                        sda_in,
    input  logic                        bit_sample,
    input  logic                        ack_sample,
    input  logic                        byte_end,
    input  logic                        xfer_start,
    output logic [i2c_pkg::DATA_W-1:0]  i2c_data_r,
    output logic                        i2c_ack
);

    import i2c_pkg::*;

    logic [DATA_W-1:0] shift_q;

    always_ff @(posedge dri_clk) begin
        if (bit_sample) begin
            shift_q <= {shift_q[DATA_W-2:0], sda_in}; // msb first
        end
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_data_r <= '0;
        end else if (byte_end) begin
            i2c_data_r <= shift_q;
        end
    end

    // sticky nack, held for the whole transfer
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_ack <= 1'b0;
        end else if (xfer_start) begin
            i2c_ack <= 1'b0;
        end else if (ack_sample && sda_in) begin
            i2c_ack <= 1'b1;
        end
    end

    a_sample_exclusive: assert property (
        @(posedge dri_clk) disable iff (!rst_n) !(bit_sample && ack_sample)
    );

endmodule

`default_nettype wire

/* i2c_ctrl/i2c_bit_engine.sv */
`default_nettype none

module i2c_bit_engine (
    input  logic                        dri_clk,
    input  logic                        rst_n,
    input  i2c_pkg::i2c_state_e         phase,
    input  logic [i2c_pkg::DATA_W-1:0]  tx_byte,
    output logic                        scl,
    output logic                        sda_out,
    output logic                        sda_dir,
    output logic                        phase_done,
    output logic                        bit_sample,
    output logic                        ack_sample,
    output logic                        byte_end
);

    import i2c_pkg::*;

    slot_cnt_t slot;
    slot_cnt_t last_slot;
    slot_cnt_t rel_slot;   // slot counted from the first data bit
    logic      is_start;
    logic      rd_phase;

    assign is_start = (phase == st_sladdr) || (phase == st_addr_rd);
    assign rd_phase = (phase == st_data_rd);
    assign rel_slot = slot - (is_start ? 7'd4 : 7'd0);

    always_comb begin
        case (phase)
            st_sladdr, st_addr_rd: last_slot = START_SLOTS;
            st_stop:               last_slot = STOP_SLOTS;
            default:               last_slot = BYTE_SLOTS;
        endcase
    end

    // scl is high during slots 4n+2 and 4n+3 of the data bits
    assign bit_sample = rd_phase && (rel_slot < 7'd32) && (rel_slot[1:0] == 2'd2);
    assign byte_end   = rd_phase && (slot == BYTE_SLOTS);
    assign ack_sample = (phase != st_idle) && (phase != st_stop) && !rd_phase
                        && (slot == last_slot - 1'b1);

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl        <= 1'b1;
            sda_out    <= 1'b1;
            sda_dir    <= 1'b1;
            phase_done <= 1'b0;
            slot       <= '0;
        end else begin
            phase_done <= 1'b0;
            if (phase == st_idle) begin
                scl     <= 1'b1;
                sda_out <= 1'b1;
                sda_dir <= 1'b1;
                slot    <= '0;
            end else begin
                slot <= (slot == last_slot) ? '0 : slot + 1'b1;
                if (slot == last_slot - 1'b1) begin
                    phase_done <= 1'b1;
                end
                if (phase == st_stop) begin
                    case (slot)
                        7'd0: begin
                            sda_dir <= 1'b1;
                            sda_out <= 1'b0;
                        end
                        7'd1: scl <= 1'b1;
                        7'd3: sda_out <= 1'b1;           // stop, sda rises with scl high
                        default: ;
                    endcase
                end else if (is_start && (slot < 7'd4)) begin
                    case (slot[1:0])
                        2'd0: begin
                            sda_dir <= 1'b1;
                            sda_out <= 1'b1;
                        end
                        2'd1: begin
                            scl <= 1'b1;
                            if (phase == st_sladdr) begin
                                sda_out <= 1'b0;         // start
                            end
                        end
                        2'd2: begin
                            if (phase == st_addr_rd) begin
                                sda_out <= 1'b0;         // repeated start
                            end
                        end
                        2'd3: scl <= 1'b0;
                    endcase
                end else if (rel_slot < 7'd32) begin
                    case (rel_slot[1:0])
                        2'd0: begin
                            sda_dir <= !rd_phase;        // released while reading
                            sda_out <= tx_byte[3'd7 - rel_slot[4:2]];
                        end
                        2'd1: scl <= 1'b1;
                        2'd3: scl <= 1'b0;
                        default: ;
                    endcase
                end else begin
                    case (rel_slot)
                        7'd32: begin
                            sda_dir <= rd_phase;         // master nack after read byte
                            sda_out <= 1'b1;
                        end
                        7'd33: scl <= 1'b1;
                        7'd35: scl <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end
    end

    a_bit_sample_rd: assert property (
        @(posedge dri_clk) disable iff (!rst_n)
        bit_sample |-> (phase == st_data_rd) && !sda_dir && scl
    );

    a_ack_released: assert property (
        @(posedge dri_clk) disable iff (!rst_n) ack_sample |-> !sda_dir && scl
    );

endmodule

`default_nettype wire

/* i2c_ctrl/i2c_ctrl_fsm.sv */
`default_nettype none

module i2c_ctrl_fsm #(
    parameter logic [i2c_pkg::SLV_ADDR_W-1:0] SLAVE_ADDR = 7'h1a
) (
    input  logic                        dri_clk,
    input  logic                        rst_n,
    input  logic                        i2c_exec,
    input  logic                        bit_ctrl,
    input  logic                        i2c_rh_wl,
    input  logic [i2c_pkg::ADDR_W-1:0]  i2c_addr,
    input  logic [i2c_pkg::DATA_W-1:0]  i2c_data_w,
    input  logic                        phase_done,
    output i2c_pkg::i2c_state_e         phase,
    output logic [i2c_pkg::DATA_W-1:0]  tx_byte,
    output logic                        xfer_start,
    output logic                        i2c_done
);

    import i2c_pkg::*;

    i2c_state_e          next_phase;
    logic [ADDR_W-1:0]   addr_q;
    logic [DATA_W-1:0]   data_q;
    logic                rd_q;    // 1: read transfer
    logic                wide_q;  // 1: 16-bit word address

    // a request is taken only while idle
    assign xfer_start = (phase == st_idle) && i2c_exec;

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q   <= 1'b0;
            wide_q <= 1'b0;
        end else if (xfer_start) begin
            rd_q   <= i2c_rh_wl;
            wide_q <= bit_ctrl;
        end
    end

    always_ff @(posedge dri_clk) begin
        if (xfer_start) begin
            addr_q <= i2c_addr;
            data_q <= i2c_data_w;
        end
    end

    always_comb begin
        next_phase = phase;
        case (phase)
            st_idle: begin
                if (i2c_exec) begin
                    next_phase = st_sladdr;
                end
            end
            st_sladdr: begin
                if (phase_done) begin
                    next_phase = wide_q ? st_addr16 : st_addr8;
                end
            end
            st_addr16: begin
                if (phase_done) begin
                    next_phase = st_addr8;
                end
            end
            st_addr8: begin
                if (phase_done) begin
                    next_phase = rd_q ? st_addr_rd : st_data_wr;
                end
            end
            st_addr_rd: begin
                if (phase_done) begin
                    next_phase = st_data_rd;
                end
            end
            st_data_wr, st_data_rd: begin
                if (phase_done) begin
                    next_phase = st_stop;
                end
            end
            st_stop: begin
                if (phase_done) begin
                    next_phase = st_idle;
                end
            end
            default: next_phase = st_idle;
        endcase
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= st_idle;
            i2c_done <= 1'b0;
        end else begin
            phase    <= next_phase;
            i2c_done <= (phase == st_stop) && phase_done; // one cycle on leaving stop
        end
    end

    always_comb begin
        case (phase)
            st_sladdr:  tx_byte = {SLAVE_ADDR, 1'b0};       // r/w = write
            st_addr16:  tx_byte = addr_q[ADDR_W-1:DATA_W];
            st_addr8:   tx_byte = addr_q[DATA_W-1:0];
            st_data_wr: tx_byte = data_q;
            st_addr_rd: tx_byte = {SLAVE_ADDR, 1'b1};       // r/w = read
            default:    tx_byte = '1;                       // line left high
        endcase
    end

    a_done_one_cycle: assert property (
        @(posedge dri_clk) disable iff (!rst_n) i2c_done |=> !i2c_done
    );

endmodule

`default_nettype wire

/* common/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

    localparam int DATA_W     = 8;  // one byte on the wire
    localparam int ADDR_W     = 16; // widest word address
    localparam int SLV_ADDR_W = 7;

    // transfer phases, one per byte on the bus plus idle and stop
    typedef enum logic [2:0] {
        st_idle,
        st_sladdr,   // start + slave address, write
        st_addr16,   // high word address byte
        st_addr8,    // low word address byte
        st_data_wr,
        st_addr_rd,  // restart + slave address, read
        st_data_rd,
        st_stop
    } i2c_state_e;

    typedef logic [6:0] slot_cnt_t; // dri_clk slot inside a phase

    // last slot of each phase kind, four slots per scl bit
    localparam slot_cnt_t BYTE_SLOTS  = 7'd35; // 8 bits + ack
    localparam slot_cnt_t START_SLOTS = 7'd39; // start slot group + 8 bits + ack
    localparam slot_cnt_t STOP_SLOTS  = 7'd16;

endpackage

`default_nettype wire
